/* logic/i3c_target_pkg.sv */
// Bus widths, sequencer states, SDA drive modes and the received byte union
`default_nettype none

package i3c_target_pkg;

  // Width of one bus byte
  localparam int ByteWidth = 8;
  // Width of the static target address
  localparam int AddrWidth = 7;
  // Bit counter runs 0 to 8, index 8 is the ACK/T slot
  localparam int BitIdxWidth = 4;

  // Sequencer states
  typedef enum logic [3:0] {
    Idle,
    AddrRead,
    AddrAckWait,
    AddrAckDrive,
    AddrAckHold,
    TxLoad,
    TxDrive,
    TxHold,
    TxAck,
    RxByte,
    RxAckWait,
    RxAckDrive,
    RxAckHold,
    WaitForStop
  } seq_state_e;

  // What the driver puts on SDA
  typedef enum logic [1:0] {
    Release,
    DriveLow,
    DriveTxBit
  } drive_mode_e;

  // First byte after a Start, address in the upper bits
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 rnw;
  } addr_hdr_t;

  // Same byte seen as header or as write data
  typedef union packed {
    addr_hdr_t            hdr;
    logic [ByteWidth-1:0] data;
  } rx_byte_u;

endpackage

`default_nettype wire

/* logic/i3c_bus_event_if.sv */
// Bus event interface and SDA control interface
`timescale 1ns/10ps
`default_nettype none

interface i3c_bus_event_if;

  // One-cycle SCL edge flags
  logic scl_rise;
  logic scl_fall;
  // Sampled SDA level
  logic sda;
  // One-cycle bus condition flags
  logic start;
  logic stop;

  modport sampler_mp (output scl_rise, output scl_fall, output sda, output start, output stop);
  modport consumer_mp (input scl_rise, input scl_fall, input sda, input start, input stop);

endinterface

interface sda_ctrl_if;

  // Requested SDA behaviour from the sequencer
  i3c_target_pkg::drive_mode_e drive_mode;
  // Restart of the hold timer
  logic hold_load;
  // Hold timer expired
  logic hold_done;

  modport seq_mp (output drive_mode, output hold_load, input hold_done);
  modport drv_mp (input drive_mode, input hold_load, output hold_done);

endinterface

`default_nettype wire

/* logic/i3c_bus_sampler.sv */
// Pin sampler with SCL edge, Start and Stop detection
`timescale 1ns/10ps
`default_nettype none

module i3c_bus_sampler (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 scl_i,
  input  wire                 sda_i,
  i3c_bus_event_if.sampler_mp bus_if
);

  // Registered pins
  logic scl_q;
  logic sda_q;
  // Previous sample, for edges
  logic scl_prev_q;
  logic sda_prev_q;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_q      <= scl_i;
      sda_q      <= sda_i;
      scl_prev_q <= scl_q;
      sda_prev_q <= sda_q;
    end
  end

  // SCL edges, one cycle after the pin change
  assign bus_if.scl_rise = scl_q & ~scl_prev_q;
  assign bus_if.scl_fall = ~scl_q & scl_prev_q;
  assign bus_if.sda      = sda_q;

  // SDA moves while SCL stays high
  // falling SDA is Start, rising SDA is Stop
  assign bus_if.start = scl_q & scl_prev_q & sda_prev_q & ~sda_q;
  assign bus_if.stop  = scl_q & scl_prev_q & ~sda_prev_q & sda_q;

  // Start and Stop never coincide
  start_stop_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_if.start && bus_if.stop));

endmodule

`default_nettype wire

/* logic/i3c_byte_shifter.sv */
// Bit counter, byte shift register, host ACK capture and address check
`timescale 1ns/10ps
`default_nettype none

module i3c_byte_shifter (
  input  wire                                    clk_i,
  input  wire                                    rst_ni,
  i3c_bus_event_if.consumer_mp                   bus_if,
  input  wire i3c_target_pkg::seq_state_e        state_i,
  input  wire [i3c_target_pkg::AddrWidth-1:0]    target_addr_i,
  input  wire                                    enable_i,
  output logic [i3c_target_pkg::BitIdxWidth-1:0] bit_idx_o,
  output logic                                   byte_done_o,
  output i3c_target_pkg::rx_byte_u               rx_byte_o,
  output logic                                   host_ack_o,
  output logic                                   addr_match_o
);

  localparam int IdxW  = i3c_target_pkg::BitIdxWidth;
  localparam int ByteW = i3c_target_pkg::ByteWidth;
  // ACK/T slot and last data bit
  localparam logic [IdxW-1:0] AckIdx  = IdxW'(ByteW);
  localparam logic [IdxW-1:0] LastIdx = IdxW'(ByteW - 1);

  logic [IdxW-1:0]          bit_idx_q;
  logic                     skip_fall_q;
  logic                     at_ack;
  logic                     host_ack_q;
  logic                     addr_match_q;
  i3c_target_pkg::rx_byte_u rx_byte_q;
  i3c_target_pkg::rx_byte_u rx_byte_nxt;

  assign at_ack = (bit_idx_q == AckIdx);

  // Byte after the next shift, MSB first
  always_comb begin
    rx_byte_nxt.data = {rx_byte_q.data[ByteW-2:0], bus_if.sda};
  end

  // Index moves on SCL fall
  // The fall that closes a Start is not a bit boundary
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q   <= '0;
      skip_fall_q <= 1'b0;
    end else if (!enable_i || bus_if.start) begin
      bit_idx_q   <= '0;
      skip_fall_q <= enable_i;
    end else if (bus_if.scl_fall) begin
      skip_fall_q <= 1'b0;
      if (skip_fall_q || at_ack) begin
        bit_idx_q <= '0;
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
      end
    end
  end

  // Data bits shift in on SCL rise, ACK slot excluded
  always_ff @(posedge clk_i) begin
    if (bus_if.start) begin
      rx_byte_q.data <= '0;
    end else if (bus_if.scl_rise && !at_ack) begin
      rx_byte_q <= rx_byte_nxt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q   <= 1'b0;
      addr_match_q <= 1'b0;
    end else begin
      // Host pulls SDA low to acknowledge
      if (bus_if.scl_rise && at_ack) begin
        host_ack_q <= ~bus_if.sda;
      end
      // Address compare as the eighth bit comes in
      if (!enable_i || bus_if.start) begin
        addr_match_q <= 1'b0;
      end else if (bus_if.scl_rise && (bit_idx_q == LastIdx) &&
                   (state_i == i3c_target_pkg::AddrRead)) begin
        addr_match_q <= (rx_byte_nxt.hdr.addr == target_addr_i);
      end
    end
  end

  assign bit_idx_o    = bit_idx_q;
  assign byte_done_o  = at_ack;
  assign rx_byte_o    = rx_byte_q;
  assign host_ack_o   = host_ack_q;
  assign addr_match_o = addr_match_q;

  // Index stays within the nine-slot frame
  bit_idx_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bit_idx_q <= AckIdx);

endmodule

`default_nettype wire

/* logic/i3c_target_seq.sv */
// Protocol sequencer for address, write and read phases with FIFO handshakes
`timescale 1ns/10ps
`default_nettype none

module i3c_target_seq (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire                                   enable_i,
  i3c_bus_event_if.consumer_mp                  bus_if,
  sda_ctrl_if.seq_mp                            sda_if,
  input  wire [i3c_target_pkg::BitIdxWidth-1:0] bit_idx_i,
  input  wire                                   byte_done_i,
  input  wire i3c_target_pkg::rx_byte_u         rx_byte_i,
  input  wire                                   host_ack_i,
  input  wire                                   addr_match_i,
  output i3c_target_pkg::seq_state_e            state_o,
  input  wire                                   tx_valid_i,
  output logic                                  tx_ready_o,
  output logic                                  rx_valid_o,
  output logic [i3c_target_pkg::ByteWidth-1:0]  rx_data_o,
  input  wire                                   rx_ready_i,
  output logic                                  target_idle_o,
  output logic                                  cmd_complete_o
);

  localparam int IdxW = i3c_target_pkg::BitIdxWidth;
  localparam logic [IdxW-1:0] AckIdx = IdxW'(i3c_target_pkg::ByteWidth);

  i3c_target_pkg::seq_state_e state_q;
  i3c_target_pkg::seq_state_e state_d;
  // Transaction addressed to this target
  logic addressed_q;
  logic addressed_d;
  // Host asked for a read
  logic rnw_q;
  logic rnw_d;
  // TX byte present when the read byte started
  logic tx_have_q;
  logic tx_have_d;
  logic rx_push;
  logic rx_valid_q;
  logic cmd_complete_q;
  logic [i3c_target_pkg::ByteWidth-1:0] rx_data_q;
  i3c_target_pkg::drive_mode_e tx_mode;

  // Missing TX data leaves SDA released
  assign tx_mode = tx_have_q ? i3c_target_pkg::DriveTxBit : i3c_target_pkg::Release;

  always_comb begin
    state_d           = state_q;
    addressed_d       = addressed_q;
    rnw_d             = rnw_q;
    tx_have_d         = tx_have_q;
    sda_if.drive_mode = i3c_target_pkg::Release;
    sda_if.hold_load  = 1'b0;
    tx_ready_o        = 1'b0;
    rx_push           = 1'b0;
    unique case (state_q)
      i3c_target_pkg::Idle: begin
        addressed_d = 1'b0;
      end
      // Address byte, header view of the shifter
      i3c_target_pkg::AddrRead: begin
        if (byte_done_i) begin
          rnw_d = rx_byte_i.hdr.rnw;
          if (addr_match_i) begin
            addressed_d      = 1'b1;
            sda_if.hold_load = 1'b1;
            state_d          = i3c_target_pkg::AddrAckWait;
          end else begin
            state_d = i3c_target_pkg::WaitForStop;
          end
        end
      end
      // SCL rising here means the host is too fast
      i3c_target_pkg::AddrAckWait: begin
        if (bus_if.scl_rise) begin
          state_d = i3c_target_pkg::WaitForStop;
        end else if (sda_if.hold_done) begin
          state_d = i3c_target_pkg::AddrAckDrive;
        end
      end
      // ACK low until the ninth SCL fall
      i3c_target_pkg::AddrAckDrive: begin
        sda_if.drive_mode = i3c_target_pkg::DriveLow;
        if (bus_if.scl_fall) begin
          sda_if.hold_load = 1'b1;
          state_d          = i3c_target_pkg::AddrAckHold;
        end
      end
      i3c_target_pkg::AddrAckHold: begin
        sda_if.drive_mode = i3c_target_pkg::DriveLow;
        if (sda_if.hold_done) begin
          state_d = rnw_q ? i3c_target_pkg::TxLoad : i3c_target_pkg::RxByte;
        end
      end
      // Sample TX valid once per byte, first bit after one hold time
      i3c_target_pkg::TxLoad: begin
        tx_have_d        = tx_valid_i;
        sda_if.hold_load = 1'b1;
        state_d          = i3c_target_pkg::TxHold;
      end
      i3c_target_pkg::TxDrive: begin
        sda_if.drive_mode = tx_mode;
        if (bus_if.scl_fall) begin
          sda_if.hold_load = 1'b1;
          state_d          = i3c_target_pkg::TxHold;
        end
      end
      // Old bit stays until the hold time is over
      i3c_target_pkg::TxHold: begin
        sda_if.drive_mode = tx_mode;
        if (sda_if.hold_done) begin
          state_d = (bit_idx_i == AckIdx) ? i3c_target_pkg::TxAck : i3c_target_pkg::TxDrive;
        end
      end
      // Pop after the host's ACK bit, ACK or NACK
      i3c_target_pkg::TxAck: begin
        if (bus_if.scl_fall) begin
          tx_ready_o = tx_have_q;
          state_d    = host_ack_i ? i3c_target_pkg::TxLoad : i3c_target_pkg::WaitForStop;
        end
      end
      // Unaccepted previous byte gets a NACK
      i3c_target_pkg::RxByte: begin
        if (byte_done_i) begin
          if (rx_valid_q && !rx_ready_i) begin
            state_d = i3c_target_pkg::WaitForStop;
          end else begin
            sda_if.hold_load = 1'b1;
            state_d          = i3c_target_pkg::RxAckWait;
          end
        end
      end
      i3c_target_pkg::RxAckWait: begin
        if (bus_if.scl_rise) begin
          state_d = i3c_target_pkg::WaitForStop;
        end else if (sda_if.hold_done) begin
          state_d = i3c_target_pkg::RxAckDrive;
        end
      end
      i3c_target_pkg::RxAckDrive: begin
        sda_if.drive_mode = i3c_target_pkg::DriveLow;
        if (bus_if.scl_fall) begin
          sda_if.hold_load = 1'b1;
          state_d          = i3c_target_pkg::RxAckHold;
        end
      end
      // Byte goes out as the ACK hold ends
      i3c_target_pkg::RxAckHold: begin
        sda_if.drive_mode = i3c_target_pkg::DriveLow;
        if (sda_if.hold_done) begin
          rx_push = 1'b1;
          state_d = i3c_target_pkg::RxByte;
        end
      end
      i3c_target_pkg::WaitForStop: begin
        state_d = i3c_target_pkg::WaitForStop;
      end
      default: begin
        state_d = i3c_target_pkg::Idle;
      end
    endcase

    // Bus conditions override the state
    if (!enable_i) begin
      state_d = i3c_target_pkg::Idle;
    end else if (bus_if.start) begin
      state_d = i3c_target_pkg::AddrRead;
    end else if (bus_if.stop) begin
      state_d = i3c_target_pkg::Idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= i3c_target_pkg::Idle;
      addressed_q    <= 1'b0;
      rnw_q          <= 1'b0;
      tx_have_q      <= 1'b0;
      rx_valid_q     <= 1'b0;
      cmd_complete_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      addressed_q    <= addressed_d;
      rnw_q          <= rnw_d;
      tx_have_q      <= tx_have_d;
      cmd_complete_q <= enable_i & bus_if.stop & addressed_q;
      // Valid holds until ready
      if (rx_push) begin
        rx_valid_q <= 1'b1;
      end else if (rx_ready_i) begin
        rx_valid_q <= 1'b0;
      end
    end
  end

  // Data view of the received byte
  always_ff @(posedge clk_i) begin
    if (rx_push) begin
      rx_data_q <= rx_byte_i.data;
    end
  end

  assign state_o        = state_q;
  assign rx_valid_o     = rx_valid_q;
  assign rx_data_o      = rx_data_q;
  assign target_idle_o  = (state_q == i3c_target_pkg::Idle);
  assign cmd_complete_o = cmd_complete_q;

  // Byte on the RX port is held under back-pressure
  rx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o));

endmodule

`default_nettype wire

/* logic/i3c_sda_driver.sv */
// Hold-time counter, transmit bit select and registered SDA output
`timescale 1ns/10ps
`default_nettype none

module i3c_sda_driver #(
  parameter int ThdWidth = 8
) (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  sda_ctrl_if.drv_mp                            sda_if,
  input  wire [ThdWidth-1:0]                    thd_dat_i,
  input  wire [i3c_target_pkg::ByteWidth-1:0]   tx_data_i,
  input  wire [i3c_target_pkg::BitIdxWidth-1:0] bit_idx_i,
  output logic                                  sda_o
);

  localparam int ByteW = i3c_target_pkg::ByteWidth;
  localparam int SelW  = $clog2(ByteW);

  logic [ThdWidth-1:0] hold_cnt_q;
  logic [ThdWidth-1:0] hold_len;
  logic [SelW-1:0]     tx_sel;
  logic                tx_bit_q;
  logic                tx_bit_d;
  logic                sda_q;
  logic                sda_d;

  // Zero hold is one cycle
  assign hold_len = (thd_dat_i == '0) ? ThdWidth'(1) : thd_dat_i;

  // Counter runs down to 1, then rests at 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= '0;
    end else if (sda_if.hold_load) begin
      hold_cnt_q <= hold_len;
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign sda_if.hold_done = (hold_cnt_q == ThdWidth'(1));

  // MSB goes out first
  assign tx_sel = SelW'(ByteW - 1) - bit_idx_i[SelW-1:0];

  always_comb begin
    tx_bit_d = tx_bit_q;
    // Released level until the first bit is due
    if (sda_if.drive_mode != i3c_target_pkg::DriveTxBit) begin
      tx_bit_d = 1'b1;
    end else if (sda_if.hold_done && (bit_idx_i < ByteW)) begin
      tx_bit_d = tx_data_i[tx_sel];
    end
    unique case (sda_if.drive_mode)
      i3c_target_pkg::DriveLow:   sda_d = 1'b0;
      i3c_target_pkg::DriveTxBit: sda_d = tx_bit_d;
      default:                    sda_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_bit_q <= 1'b1;
      sda_q    <= 1'b1;
    end else begin
      tx_bit_q <= tx_bit_d;
      sda_q    <= sda_d;
    end
  end

  assign sda_o = sda_q;

endmodule

`default_nettype wire

/* logic/i3c_target_top.sv */
// Target top level with sampler, shifter, sequencer and SDA driver
`timescale 1ns/10ps
`default_nettype none

module i3c_target_top #(
  parameter int ThdWidth = 8
) (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 enable_i,
  input  wire                                 scl_i,
  input  wire                                 sda_i,
  output logic                                sda_o,
  input  wire [i3c_target_pkg::AddrWidth-1:0] target_addr_i,
  input  wire [ThdWidth-1:0]                  thd_dat_i,
  input  wire                                 tx_valid_i,
  input  wire [i3c_target_pkg::ByteWidth-1:0] tx_data_i,
  output logic                                tx_ready_o,
  output logic                                rx_valid_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] rx_data_o,
  input  wire                                 rx_ready_i,
  output logic                                target_idle_o,
  output logic                                cmd_complete_o
);

  // Shifter to sequencer
  logic [i3c_target_pkg::BitIdxWidth-1:0] bit_idx;
  logic                                   byte_done;
  logic                                   host_ack;
  logic                                   addr_match;
  i3c_target_pkg::rx_byte_u               rx_byte;
  i3c_target_pkg::seq_state_e             state;

  i3c_bus_event_if bus_events ();
  sda_ctrl_if      sda_ctrl ();

  i3c_bus_sampler sampler_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .bus_if (bus_events.sampler_mp)
  );

  i3c_byte_shifter shifter_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus_if        (bus_events.consumer_mp),
    .state_i       (state),
    .target_addr_i (target_addr_i),
    .enable_i      (enable_i),
    .bit_idx_o     (bit_idx),
    .byte_done_o   (byte_done),
    .rx_byte_o     (rx_byte),
    .host_ack_o    (host_ack),
    .addr_match_o  (addr_match)
  );

  i3c_target_seq seq_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .bus_if         (bus_events.consumer_mp),
    .sda_if         (sda_ctrl.seq_mp),
    .bit_idx_i      (bit_idx),
    .byte_done_i    (byte_done),
    .rx_byte_i      (rx_byte),
    .host_ack_i     (host_ack),
    .addr_match_i   (addr_match),
    .state_o        (state),
    .tx_valid_i     (tx_valid_i),
    .tx_ready_o     (tx_ready_o),
    .rx_valid_o     (rx_valid_o),
    .rx_data_o      (rx_data_o),
    .rx_ready_i     (rx_ready_i),
    .target_idle_o  (target_idle_o),
    .cmd_complete_o (cmd_complete_o)
  );

  i3c_sda_driver #(
    .ThdWidth (ThdWidth)
  ) driver_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sda_if    (sda_ctrl.drv_mp),
    .thd_dat_i (thd_dat_i),
    .tx_data_i (tx_data_i),
    .bit_idx_i (bit_idx),
    .sda_o     (sda_o)
  );

endmodule

`default_nettype wire

/* dv/i3c_host_tasks.svh */
// Host bus model tasks for Start, Stop, byte write and byte read
`ifndef I3C_HOST_TASKS_SVH
`define I3C_HOST_TASKS_SVH

  // Plain delay in clk_i cycles, host pins move on the falling edge
  task automatic idle_clks(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // SDA falls while SCL is high, then SCL goes low
  task automatic start_condition();
    host_scl = 1'b1;
    host_sda = 1'b1;
    idle_clks(QuarterPer);
    host_sda = 1'b0;
    idle_clks(HalfPer);
    host_scl = 1'b0;
  endtask

  // SDA low during SCL low, SCL up, then SDA rises
  task automatic stop_condition();
    idle_clks(QuarterPer);
    host_sda = 1'b0;
    idle_clks(QuarterPer);
    host_scl = 1'b1;
    idle_clks(HalfPer);
    host_sda = 1'b1;
    idle_clks(HalfPer);
  endtask

  // One SCL pulse
  // SDA set mid low phase, bus sampled mid high phase
  task automatic clock_bit(input logic bit_out, output logic bit_in);
    idle_clks(QuarterPer);
    host_sda = bit_out;
    idle_clks(QuarterPer);
    host_scl = 1'b1;
    idle_clks(QuarterPer);
    bit_in = sda_bus;
    idle_clks(QuarterPer);
    host_scl = 1'b0;
  endtask

  // Eight data bits MSB first, then the target's ACK slot
  task automatic write_byte(input logic [7:0] data, output logic acked);
    logic sampled;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(data[i], sampled);
    end
    // Host lets go of SDA in the ninth slot
    clock_bit(1'b1, sampled);
    acked = ~sampled;
  endtask

  // Eight bits from the target, then host ACK or NACK
  task automatic read_byte(input logic ack, output logic [7:0] data);
    logic sampled;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, sampled);
      data[i] = sampled;
    end
    clock_bit(~ack, sampled);
  endtask

`endif

/* dv/tb_i3c_target.sv */
// Testbench top with clock, reset, host model, stimulus table, checks and report
`timescale 1ns/10ps
`default_nettype none

module tb_i3c_target;

  localparam int ThdWidth   = 8;
  localparam int HalfPer    = 20;
  localparam int QuarterPer = 10;
  localparam int NumRows    = 5;
  localparam int MaxBytes   = 4;
  localparam logic [6:0] OwnAddr = 7'h3a;

  // Stimulus row with read flag, address, byte count and RX back-pressure
  typedef struct packed {
    logic       rd;
    logic [6:0] addr;
    logic [3:0] nbytes;
    logic       hold_ready;
  } row_t;

  logic                clk_i;
  logic                rst_ni;
  logic                enable_i;
  logic                host_scl;
  logic                host_sda;
  logic                sda_o;
  logic                sda_bus;
  logic [6:0]          target_addr_i;
  logic [ThdWidth-1:0] thd_dat_i;
  logic                tx_valid_i;
  logic [7:0]          tx_data_i;
  logic                tx_ready_o;
  logic                rx_valid_o;
  logic [7:0]          rx_data_o;
  logic                rx_ready_i;
  logic                target_idle_o;
  logic                cmd_complete_o;

  row_t       rows [NumRows];
  logic [7:0] data_tab [NumRows][MaxBytes];
  logic [7:0] tx_bytes [MaxBytes];
  logic [7:0] rx_got [$];
  int         tx_pos = 0;
  int         tx_len = 0;
  int         tx_ready_cnt = 0;
  int         cmd_cnt = 0;
  int         err_cnt = 0;

  // Open-drain bus where either side can pull SDA low
  assign sda_bus = host_sda & sda_o;

  i3c_target_top #(
    .ThdWidth (ThdWidth)
  ) dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .scl_i          (host_scl),
    .sda_i          (sda_bus),
    .sda_o          (sda_o),
    .target_addr_i  (target_addr_i),
    .thd_dat_i      (thd_dat_i),
    .tx_valid_i     (tx_valid_i),
    .tx_data_i      (tx_data_i),
    .tx_ready_o     (tx_ready_o),
    .rx_valid_o     (rx_valid_o),
    .rx_data_o      (rx_data_o),
    .rx_ready_i     (rx_ready_i),
    .target_idle_o  (target_idle_o),
    .cmd_complete_o (cmd_complete_o)
  );

  `include "i3c_host_tasks.svh"

  // Wrong value with time, signal name and both values
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERR %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    err_cnt++;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Handshakes and events seen at the clock edge where they take effect
  always @(posedge clk_i) begin
    if (rx_valid_o && rx_ready_i) begin
      rx_got.push_back(rx_data_o);
    end
    if (tx_ready_o) begin
      tx_ready_cnt++;
    end
    if (cmd_complete_o) begin
      cmd_cnt++;
    end
  end

  // TX source puts the next byte up on the falling edge after a pop
  // Past the last byte it keeps offering zero bytes until the row ends
  always @(posedge clk_i) begin
    if (tx_valid_i && tx_ready_o) begin
      @(negedge clk_i);
      tx_pos++;
      if (tx_pos < tx_len) begin
        tx_data_i = tx_bytes[tx_pos];
      end else begin
        tx_data_i = 8'h00;
      end
    end
  end

  initial begin
    row_t        row;
    logic        match;
    logic        acked;
    logic        exp_ack;
    logic [7:0]  got;
    logic [31:0] rnd;
    int          seed;
    int          row_err;
    int          fail_rows;
    int          cmd_before;
    int          n_exp;
    int          waited;
    int          low_cnt;

    seed          = 32'h52b7;
    fail_rows     = 0;
    rst_ni        = 1'b0;
    enable_i      = 1'b0;
    host_scl      = 1'b1;
    host_sda      = 1'b1;
    target_addr_i = OwnAddr;
    thd_dat_i     = ThdWidth'(4);
    tx_valid_i    = 1'b0;
    tx_data_i     = 8'h00;
    rx_ready_i    = 1'b1;

    rows[0] = {1'b0, OwnAddr, 4'd3, 1'b0};
    rows[1] = {1'b0, OwnAddr ^ 7'h01, 4'd2, 1'b0};
    rows[2] = {1'b1, OwnAddr, 4'd3, 1'b0};
    rows[3] = {1'b0, OwnAddr, 4'd2, 1'b1};
    rows[4] = {1'b1, OwnAddr, 4'd1, 1'b0};
    for (int r = 0; r < NumRows; r++) begin
      for (int b = 0; b < MaxBytes; b++) begin
        rnd = $random(seed);
        data_tab[r][b] = rnd[7:0];
      end
    end

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Outputs inactive out of reset
    if (sda_o !== 1'b1) report_mismatch("sda_o", 1, sda_o);
    if (rx_valid_o !== 1'b0) report_mismatch("rx_valid_o", 0, rx_valid_o);
    if (tx_ready_o !== 1'b0) report_mismatch("tx_ready_o", 0, tx_ready_o);
    if (cmd_complete_o !== 1'b0) report_mismatch("cmd_complete_o", 0, cmd_complete_o);
    if (target_idle_o !== 1'b1) report_mismatch("target_idle_o", 1, target_idle_o);
    enable_i = 1'b1;
    idle_clks(HalfPer);

    for (int r = 0; r < NumRows; r++) begin
      row          = rows[r];
      row_err      = err_cnt;
      match        = (row.addr == OwnAddr);
      cmd_before   = cmd_cnt;
      tx_ready_cnt = 0;
      rx_got.delete();
      rx_ready_i = ~row.hold_ready;
      if (row.rd) begin
        for (int b = 0; b < MaxBytes; b++) begin
          tx_bytes[b] = data_tab[r][b];
        end
        tx_len     = row.nbytes;
        tx_pos     = 0;
        tx_data_i  = tx_bytes[0];
        tx_valid_i = 1'b1;
      end

      start_condition();
      write_byte({row.addr, row.rd}, acked);
      if (acked !== match) report_mismatch("addr_ack", match, acked);

      if (row.rd) begin
        // Host ACKs every byte but the last
        for (int b = 0; b < row.nbytes; b++) begin
          read_byte(b < row.nbytes - 1, got);
          if (got !== data_tab[r][b]) report_mismatch("read_data", data_tab[r][b], got);
        end
        low_cnt = 0;
        for (int c = 0; c < HalfPer; c++) begin
          @(negedge clk_i);
          if (sda_o !== 1'b1) low_cnt++;
        end
        if (low_cnt != 0) begin
          $display("target still drives SDA after the host NACK at %0t", $time);
          err_cnt++;
        end
      end else begin
        for (int b = 0; b < row.nbytes; b++) begin
          // Second byte under back-pressure is refused
          exp_ack = match && !(row.hold_ready && b > 0);
          write_byte(data_tab[r][b], acked);
          if (acked !== exp_ack) report_mismatch("data_ack", exp_ack, acked);
        end
        if (row.hold_ready) begin
          if (rx_valid_o !== 1'b1) report_mismatch("rx_valid_o", 1, rx_valid_o);
          if (rx_data_o !== data_tab[r][0]) begin
            report_mismatch("rx_data_o", data_tab[r][0], rx_data_o);
          end
        end
      end
      stop_condition();

      waited = 0;
      while (target_idle_o !== 1'b1 && waited < 100) begin
        @(negedge clk_i);
        waited++;
      end
      if (target_idle_o !== 1'b1) begin
        $display("timeout, target did not return to idle after Stop at %0t", $time);
        err_cnt++;
      end
      waited = 0;
      while (cmd_cnt - cmd_before < int'(match) && waited < 40) begin
        @(negedge clk_i);
        waited++;
      end
      if (cmd_cnt - cmd_before != int'(match)) begin
        report_mismatch("cmd_complete_o pulses", match, cmd_cnt - cmd_before);
      end

      if (row.rd) begin
        tx_valid_i = 1'b0;
        if (tx_ready_cnt != row.nbytes) begin
          report_mismatch("tx_ready_o pulses", row.nbytes, tx_ready_cnt);
        end
      end else begin
        if (row.hold_ready) begin
          // Byte is kept through Stop and drained afterwards
          if (rx_got.size() != 0) report_mismatch("rx bytes before ready", 0, rx_got.size());
          if (rx_data_o !== data_tab[r][0]) begin
            report_mismatch("rx_data_o", data_tab[r][0], rx_data_o);
          end
          rx_ready_i = 1'b1;
          waited = 0;
          while (rx_got.size() == 0 && waited < 40) begin
            @(negedge clk_i);
            waited++;
          end
          if (rx_got.size() == 0) begin
            $display("timeout waiting for the held RX byte at %0t", $time);
            err_cnt++;
          end
        end
        n_exp = !match ? 0 : (row.hold_ready ? 1 : int'(row.nbytes));
        if (rx_got.size() != n_exp) begin
          report_mismatch("rx byte count", n_exp, rx_got.size());
        end else begin
          for (int b = 0; b < n_exp; b++) begin
            if (rx_got[b] !== data_tab[r][b]) begin
              report_mismatch("rx_data_o", data_tab[r][b], rx_got[b]);
            end
          end
        end
      end

      if (err_cnt != row_err) fail_rows++;
      $display("row %0d %s addr 0x%02h bytes %0d: %s", r, row.rd ? "read" : "write",
               row.addr, row.nbytes, (err_cnt == row_err) ? "ok" : "FAILED");
      idle_clks(HalfPer);
    end

    $display("rows run %0d, rows failed %0d, errors %0d", NumRows, fail_rows, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+dv
logic/i3c_target_pkg.sv
logic/i3c_bus_event_if.sv
logic/i3c_bus_sampler.sv
logic/i3c_byte_shifter.sv
logic/i3c_target_seq.sv
logic/i3c_sda_driver.sv
logic/i3c_target_top.sv
dv/tb_i3c_target.sv

/* Bender.yml */
package:
  name: i3c_target

sources:
  - files:
      - logic/i3c_target_pkg.sv
      - logic/i3c_bus_event_if.sv
      - logic/i3c_bus_sampler.sv
      - logic/i3c_byte_shifter.sv
      - logic/i3c_target_seq.sv
      - logic/i3c_sda_driver.sv
      - logic/i3c_target_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_i3c_target.sv
